/* design/fp_pkg.sv */
package fp_pkg;

	// ------------------------------------------------------------------------
	// single-precision field layout
	// ------------------------------------------------------------------------
	localparam int EXP_W = 8;
	localparam int MAN_W = 23;
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX = 254; // largest finite biased exponent

	typedef logic [EXP_W+MAN_W:0] float_t;
	typedef logic [EXP_W-1:0] exp_t;
	typedef logic [MAN_W-1:0] man_t;

	function automatic logic sign_of(float_t f);
		return f[EXP_W+MAN_W];
	endfunction

	function automatic exp_t exp_of(float_t f);
		return f[EXP_W+MAN_W-1:MAN_W];
	endfunction

	function automatic man_t man_of(float_t f);
		return f[MAN_W-1:0];
	endfunction

endpackage

/* design/node_pkg.sv */
package node_pkg;

	localparam int N_INPUTS = 10;

	typedef logic [3:0] index_t;

	// element 0 sits in the leftmost slot, so WEIGHTS[i] belongs to activation i
	typedef fp_pkg::float_t [0:N_INPUTS-1] weight_vec_t;

	localparam weight_vec_t REF_WEIGHTS = '{
		32'hBEF28A3B,
		32'h3E9CFBFA,
		32'h3F061ECA,
		32'hBE01ED80,
		32'hBEF49A5E,
		32'h3B7FD1CD,
		32'hBF20A20A,
		32'h3E0B1607,
		32'h3EC0EDA5,
		32'h3CA5FB5D
	};

endpackage

/* design/sample_if.sv */
`timescale 1ns/1ps

interface sample_if;
	import fp_pkg::*;
	import node_pkg::*;

	logic start; // one-cycle launch of a weighted sum
	logic busy; // high while execute owns the buffer
	index_t rd_index;
	float_t rd_data;

	modport decode (
		output start,
		output rd_data,
		input busy,
		input rd_index
	);

	modport execute (
		input start,
		input rd_data,
		output busy,
		output rd_index
	);

endinterface

/* design/sample_decode.sv */
`timescale 1ns/1ps

module sample_decode (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input node_pkg::index_t in_index,
	input fp_pkg::float_t in_data,
	sample_if.decode smp,
	output logic overrun
);
	import fp_pkg::*;
	import node_pkg::*;

	float_t buffer [N_INPUTS];
	logic accept;
	logic in_range;
	logic last;

	// a sum in flight owns the buffer until execute drops busy
	assign accept = in_valid && !smp.start && !smp.busy;
	assign in_range = in_index < N_INPUTS;
	assign last = in_index == index_t'(N_INPUTS - 1);

	// ------------------------------------------------------------------------
	// activation buffer and launch
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < N_INPUTS; i++)
			begin
				buffer[i] <= '0;
			end
			smp.start <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			smp.start <= accept && last;
			if (accept && in_range)
			begin
				buffer[in_index] <= in_data;
			end
			if (in_valid && !accept)
			begin
				overrun <= 1'b1; // sticky until reset
			end
		end
	end

	assign smp.rd_data = (smp.rd_index < N_INPUTS) ? buffer[smp.rd_index] : '0;

endmodule

/* design/float_mult.sv */
`timescale 1ns/1ps

module float_mult (
	input fp_pkg::float_t x,
	input fp_pkg::float_t y,
	output fp_pkg::float_t z
);
	import fp_pkg::*;

	logic sgn;
	logic [47:0] prod;
	logic signed [9:0] e_res;
	man_t m_res;
	logic zero_in;

	always_comb
	begin
		sgn = sign_of(x) ^ sign_of(y);
		zero_in = (exp_of(x) == '0) || (exp_of(y) == '0); // denormals count as zero
		prod = {1'b1, man_of(x)} * {1'b1, man_of(y)};
		e_res = 10'(exp_of(x)) + 10'(exp_of(y)) - 10'(EXP_BIAS);

		// product of two 1.x mantissas lies in [1, 4)
		if (prod[47])
		begin
			m_res = prod[46:24];
			e_res = e_res + 10'sd1;
		end
		else
		begin
			m_res = prod[45:23];
		end

		if (zero_in || e_res <= 0)
		begin
			z = '0;
		end
		else if (e_res > EXP_MAX)
		begin
			z = {sgn, exp_t'(EXP_MAX), {MAN_W{1'b1}}}; // saturate to largest finite
		end
		else
		begin
			z = {sgn, e_res[EXP_W-1:0], m_res};
		end
	end

endmodule

/* design/float_adder.sv */
`timescale 1ns/1ps

module float_adder (
	input fp_pkg::float_t a,
	input fp_pkg::float_t b,
	output fp_pkg::float_t sum
);
	import fp_pkg::*;

	float_t big;
	float_t lesser;
	exp_t diff;
	logic [24:0] m_big; // carry bit, hidden bit, fraction
	logic [24:0] m_small;
	logic [24:0] m_raw;
	logic [24:0] m_norm;
	logic [4:0] lz;
	logic signed [9:0] e_res;

	always_comb
	begin
		// magnitude order falls out of the raw bits for normal numbers
		if (a[30:0] >= b[30:0])
		begin
			big = a;
			lesser = b;
		end
		else
		begin
			big = b;
			lesser = a;
		end

		diff = exp_of(big) - exp_of(lesser);
		m_big = (exp_of(big) == '0) ? '0 : {2'b01, man_of(big)};
		m_small = (exp_of(lesser) == '0) ? '0 : {2'b01, man_of(lesser)};
		m_small = m_small >> diff; // bits shifted out are truncated

		if (sign_of(big) == sign_of(lesser))
		begin
			m_raw = m_big + m_small;
		end
		else
		begin
			m_raw = m_big - m_small;
		end

		lz = '0;
		for (int i = 0; i < 24; i++)
		begin
			if (m_raw[i])
			begin
				lz = 5'(23 - i); // highest set bit wins
			end
		end

		if (m_raw[24])
		begin
			m_norm = m_raw >> 1;
			e_res = 10'(exp_of(big)) + 10'sd1;
		end
		else
		begin
			m_norm = m_raw << lz;
			e_res = 10'(exp_of(big)) - 10'(lz);
		end

		if (m_raw == '0 || e_res <= 0)
		begin
			sum = '0; // exact cancellation is +0
		end
		else if (e_res > EXP_MAX)
		begin
			sum = {sign_of(big), exp_t'(EXP_MAX), {MAN_W{1'b1}}};
		end
		else
		begin
			sum = {sign_of(big), e_res[EXP_W-1:0], m_norm[MAN_W-1:0]};
		end
	end

endmodule

/* design/node_execute.sv */
`timescale 1ns/1ps

module node_execute #(
	parameter node_pkg::weight_vec_t WEIGHTS = node_pkg::REF_WEIGHTS
) (
	input logic clk,
	input logic rst_n,
	sample_if.execute smp,
	output logic sum_valid,
	output fp_pkg::float_t sum
);
	import fp_pkg::*;
	import node_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ACCUM,
		DONE
	} state_t;

	state_t state;
	index_t idx;
	float_t acc;
	float_t weight;
	float_t product;
	float_t acc_next;

	assign weight = WEIGHTS[idx]; // idx never passes the last element

	float_mult u_mult (
		.x(smp.rd_data),
		.y(weight),
		.z(product)
	);

	float_adder u_add (
		.a(acc),
		.b(product),
		.sum(acc_next)
	);

	// ------------------------------------------------------------------------
	// one multiply-accumulate per cycle over the ten elements
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			idx <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (smp.start)
					begin
						state <= ACCUM;
						idx <= '0;
					end
				end
				ACCUM:
				begin
					if (idx == index_t'(N_INPUTS - 1))
					begin
						state <= DONE;
					end
					else
					begin
						idx <= idx + 1'b1;
					end
				end
				default:
				begin
					state <= IDLE; // DONE lasts one cycle
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == IDLE && smp.start)
		begin
			acc <= '0;
		end
		else if (state == ACCUM)
		begin
			acc <= acc_next;
		end
	end

	assign smp.busy = state != IDLE;
	assign smp.rd_index = idx;
	assign sum_valid = state == DONE;
	assign sum = acc;

endmodule

/* design/node_result.sv */
`timescale 1ns/1ps

module node_result (
	input logic clk,
	input logic rst_n,
	input logic sum_valid,
	input fp_pkg::float_t sum,
	output logic out_valid,
	output fp_pkg::float_t out_data,
	output logic clamped
);
	import fp_pkg::*;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			clamped <= 1'b0;
		end
		else
		begin
			out_valid <= sum_valid;
			if (sum_valid)
			begin
				clamped <= sign_of(sum); // a -0 sum is clamped too
			end
		end
	end

	// relu on the way into the output register
	always_ff @(posedge clk)
	begin
		if (sum_valid)
		begin
			out_data <= sign_of(sum) ? '0 : sum;
		end
	end

endmodule

/* design/node_top.sv */
`timescale 1ns/1ps

module node_top #(
	parameter node_pkg::weight_vec_t WEIGHTS = node_pkg::REF_WEIGHTS
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input node_pkg::index_t in_index,
	input fp_pkg::float_t in_data,
	output logic out_valid,
	output fp_pkg::float_t out_data,
	output logic clamped,
	output logic overrun
);
	import fp_pkg::*;

	logic sum_valid;
	float_t sum;

	sample_if smp ();

	sample_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_index(in_index),
		.in_data(in_data),
		.smp(smp.decode),
		.overrun(overrun)
	);

	node_execute #(
		.WEIGHTS(WEIGHTS)
	) u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.smp(smp.execute),
		.sum_valid(sum_valid),
		.sum(sum)
	);

	node_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.sum_valid(sum_valid),
		.sum(sum),
		.out_valid(out_valid),
		.out_data(out_data),
		.clamped(clamped)
	);

endmodule

/* bench/node_tb.sv */
`timescale 1ns/1ps

module node_tb;
	import fp_pkg::*;
	import node_pkg::*;

	localparam int TIMEOUT = 40;
	localparam int LATENCY = 12;

	// 0.5, -1.0, 2.0, 0.25, -0.5, 1.0, 4.0, -2.0, 0.125, 1.5
	localparam weight_vec_t TB_WEIGHTS = '{
		32'h3F000000, 32'hBF800000, 32'h40000000, 32'h3E800000, 32'hBF000000,
		32'h3F800000, 32'h40800000, 32'hC0000000, 32'h3E000000, 32'h3FC00000
	};

	logic clk;
	logic rst_n;
	logic in_valid;
	index_t in_index;
	float_t in_data;
	logic out_valid;
	float_t out_data;
	logic clamped;
	logic overrun;

	int errors;
	integer seed;
	bit waiting; // high while a result is expected
	int act [N_INPUTS]; // activations of the vector under test

	node_top #(
		.WEIGHTS(TB_WEIGHTS)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_index(in_index),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_data(out_data),
		.clamped(clamped),
		.overrun(overrun)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// protocol checks that hold over the whole run
	// ------------------------------------------------------------------------
	assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
	else
	begin
		$display("out_valid stayed high for more than one cycle");
		errors++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> waiting)
	else
	begin
		$display("out_valid pulsed while no result was pending");
		errors++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) overrun |=> overrun)
	else
	begin
		$display("overrun dropped before reset");
		errors++;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic real weight_value(int i);
		case (i)
			0: return 0.5;
			1: return -1.0;
			2: return 2.0;
			3: return 0.25;
			4: return -0.5;
			5: return 1.0;
			6: return 4.0;
			7: return -2.0;
			8: return 0.125;
			default: return 1.5;
		endcase
	endfunction

	// repack a double into single format, exact for the small values used here
	function automatic float_t real_to_float(real r);
		logic [63:0] d;
		logic [10:0] e;
		d = $realtobits(r);
		e = d[62:52];
		if (e == '0)
		begin
			return '0;
		end
		return {d[63], 8'(e - 11'd896), d[51:29]};
	endfunction

	function automatic real model_sum();
		real s;
		s = 0.0;
		for (int i = 0; i < N_INPUTS; i++)
		begin
			s = s + weight_value(i) * act[i];
		end
		return s;
	endfunction

	// ------------------------------------------------------------------------
	// stimulus and checking tasks
	// ------------------------------------------------------------------------
	task automatic write_elem(input index_t i, input float_t d);
		@(posedge clk);
		in_valid <= 1'b1;
		in_index <= i;
		in_data <= d;
	endtask

	task automatic end_writes();
		@(posedge clk);
		in_valid <= 1'b0; // this edge samples the last write
	endtask

	task automatic check_result(input string name);
		real s;
		float_t exp_data;
		logic exp_clamp;
		s = model_sum();
		exp_clamp = s < 0.0;
		exp_data = exp_clamp ? '0 : real_to_float(s);
		assert (out_data == exp_data)
		else
		begin
			$display("Mismatch in %s: expected %h, actual %h", name, exp_data, out_data);
			errors++;
		end
		assert (clamped == exp_clamp)
		else
		begin
			$display("Mismatch in %s clamped: expected %b, actual %b", name, exp_clamp, clamped);
			errors++;
		end
	endtask

	// a latency of zero skips the latency check
	task automatic wait_and_check(input string name, input int latency);
		int edges;
		bit got;
		edges = 0;
		got = 1'b0;
		waiting = 1'b1;
		while (!got && edges < TIMEOUT)
		begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			got = out_valid;
		end
		if (got)
		begin
			check_result(name);
			if (latency > 0)
			begin
				assert (edges == latency)
				else
				begin
					$display("Mismatch in %s latency: expected %0d, actual %0d",
						name, latency, edges);
					errors++;
				end
			end
			@(posedge clk); // let the pulse end before the window closes
			@(negedge clk);
		end
		else
		begin
			$display("%s: out_valid did not rise within %0d cycles", name, TIMEOUT);
			errors++;
		end
		waiting = 1'b0;
	endtask

	task automatic run_vector(input string name, input bit check_latency);
		for (int i = 0; i < N_INPUTS; i++)
		begin
			write_elem(index_t'(i), real_to_float(real'(act[i])));
		end
		end_writes();
		wait_and_check(name, check_latency ? LATENCY : 0);
	endtask

	initial
	begin
		logic [31:0] r;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_index = '0;
		in_data = '0;
		errors = 0;
		seed = 32'h3d60;
		waiting = 1'b0;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		assert (!out_valid && !clamped && !overrun)
		else
		begin
			$display("outputs not cleared after reset");
			errors++;
		end

		act = '{2, 1, 3, 4, -2, 2, 1, -1, 4, 2}; // sums to 19.5
		run_vector("positive", 1'b1);
		act = '{-2, 3, -1, 0, 4, -3, -2, 5, 0, -1}; // sums to -30.5
		run_vector("relu", 1'b0);
		act = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		run_vector("zero", 1'b0);

		// shuffled order with a stray write to index 12
		act = '{-3, 5, 1, -8, 7, 2, -1, 3, 6, -4};
		write_elem(4'd4, real_to_float(real'(act[4])));
		write_elem(4'd0, real_to_float(real'(act[0])));
		write_elem(4'd7, real_to_float(real'(act[7])));
		write_elem(4'd12, 32'h42F60000);
		write_elem(4'd2, real_to_float(real'(act[2])));
		write_elem(4'd8, real_to_float(real'(act[8])));
		write_elem(4'd1, real_to_float(real'(act[1])));
		write_elem(4'd5, real_to_float(real'(act[5])));
		write_elem(4'd3, real_to_float(real'(act[3])));
		write_elem(4'd6, real_to_float(real'(act[6])));
		write_elem(4'd9, real_to_float(real'(act[9])));
		end_writes();
		wait_and_check("shuffled", LATENCY);
		assert (!overrun)
		else
		begin
			$display("overrun set without a write in the busy window");
			errors++;
		end

		// writes during the busy window must not touch the running sum
		act = '{1, -2, 3, 2, -1, 4, 2, 1, -5, 3};
		for (int i = 0; i < N_INPUTS; i++)
		begin
			write_elem(index_t'(i), real_to_float(real'(act[i])));
		end
		end_writes();
		write_elem(4'd3, 32'h41200000);
		write_elem(4'd9, 32'hC1000000);
		end_writes();
		wait_and_check("overrun", 0);
		assert (overrun)
		else
		begin
			$display("overrun not set by a write in the busy window");
			errors++;
		end
		act = '{7, 6, -5, 4, -3, 2, -1, 0, 1, -2};
		run_vector("after_overrun", 1'b1);

		for (int n = 0; n < 20; n++)
		begin
			for (int i = 0; i < N_INPUTS; i++)
			begin
				r = $random(seed);
				act[i] = $signed(r[3:0]); // -8 to 7
			end
			run_vector($sformatf("random_%0d", n), 1'b1);
		end

		repeat (4) @(posedge clk);
		$display("errors: %0d", errors);
		if (errors == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* all.f */
design/fp_pkg.sv
design/node_pkg.sv
design/sample_if.sv
design/sample_decode.sv
design/float_mult.sv
design/float_adder.sv
design/node_execute.sv
design/node_result.sv
design/node_top.sv
bench/node_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the neuron testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -Wno-fatal --top-module node_tb \
	-f all.f -o node_sim

./obj_dir/node_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
